// ==== sim/mem_trace.txt ====
// cmd sw ac skip ifield dfield mask | expected instruction eaddr mdout, all hex
// cmd 10 load 08 deposit 04 examine 02 run, ff ends; mask 4 instruction 2 eaddr 1 mdout
10 008 000 0 0 0 2 000 0008 000  // load 0010
08 0ff 000 0 0 0 3 000 0009 0ff  // 0377 auto-index pointer
10 028 000 0 0 0 2 000 0028 000  // load 0050
08 29c 000 0 0 0 3 000 0029 29c  // 1234 page 0 data
10 080 000 0 0 0 2 000 0080 000  // load 0200
08 228 000 0 0 0 3 000 0081 228  // 1050 TAD 0050
08 2a8 000 0 0 0 3 000 0082 2a8  // 1250 TAD 0250
08 308 000 0 0 0 3 000 0083 308  // 1410 TAD I 0010
08 6a9 000 0 0 0 3 000 0084 6a9  // 3251 DCA 0251
08 8b0 000 0 0 0 3 000 0085 8b0  // 4260 JMS 0260
10 0a8 000 0 0 0 2 000 00a8 000  // load 0250
08 8d1 000 0 0 0 3 000 00a9 8d1  // 4321 current page data
08 000 000 0 0 0 3 000 00aa 000  // DCA target
08 fff 000 0 0 0 3 000 00ab fff  // 7777 ISZ target
10 0b0 000 0 0 0 2 000 00b0 000  // load 0260
08 000 000 0 0 0 3 000 00b1 000  // JMS target
08 4aa 000 0 0 0 3 000 00b2 4aa  // 2252 ISZ 0252
08 f02 000 0 0 0 3 000 00b3 f02  // 7402 skipped
08 e00 000 0 0 0 3 000 00b4 e00  // 7000 NOP
08 f02 000 0 0 0 3 000 00b5 f02  // 7402 skipped
08 ab8 000 0 0 0 3 000 00b6 ab8  // 5270 JMP 0270
10 100 000 0 0 0 2 000 0100 000  // load 0400
08 02d 000 0 0 0 3 000 0101 02d  // 0055 in field 0
10 100 000 0 1 0 2 000 1100 000  // load 1 0400
08 d63 000 0 1 0 3 000 1101 d63  // 6543 in field 1
10 080 000 0 0 0 2 000 0080 000  // load 0200
04 000 000 0 0 0 3 000 0081 228  // examine 1050
04 000 000 0 0 0 3 000 0082 2a8  // examine 1250
10 080 000 0 0 0 2 000 0080 000  // load 0200 to run
02 000 000 0 0 0 7 228 0081 29c  // TAD page 0
02 000 000 0 0 0 7 2a8 0082 8d1  // TAD current page
02 000 000 0 0 1 7 308 0083 d63  // TAD I 0010, data field 1
02 000 555 0 0 0 7 6a9 0084 000  // DCA 0251 with AC 2525
02 000 000 0 0 0 7 8b0 00b1 000  // JMS 0260
02 000 000 0 0 0 7 4aa 00b3 fff  // ISZ 0252 skips
02 000 000 1 0 0 7 e00 00b5 e00  // NOP with skip high
02 000 000 0 0 0 7 ab8 00b8 ab8  // JMP 0270
10 008 000 0 0 0 2 000 0008 000  // load 0010
04 000 000 0 0 0 3 000 0009 100  // pointer now 0400
10 0a9 000 0 0 0 2 000 00a9 000  // load 0251
04 000 000 0 0 0 3 000 00aa 555  // stored AC
04 000 000 0 0 0 3 000 00ab 000  // ISZ result
10 0b0 000 0 0 0 2 000 00b0 000  // load 0260
04 000 000 0 0 0 3 000 00b1 085  // return address 0205
10 100 000 0 0 0 2 000 0100 000  // load 0400
04 000 000 0 0 0 3 000 0101 02d  // field 0 word unchanged
ff

// ==== sim.f ====
design/pdp8_mem_pkg.sv
design/major_state_seq.sv
design/memory_address_unit.sv
design/core_field_bank.sv
design/field_read_merge.sv
design/memory_subsystem.sv
sim/memory_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module memory_subsystem_tb -f sim.f -o memory_subsystem_tb \
  && ./obj_dir/memory_subsystem_tb \
  || exit 1

// ==== sim/memory_subsystem_tb.sv ====
module memory_subsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FIELDS   = 2;
  localparam int CLK_HALF     = 20;  // 40 ns period
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 10;
  localparam int LINE_CYCLES  = 40;  // Timeout budget per trace line
  localparam int LINE_WORDS   = 10;  // Values on each trace line
  localparam int MAX_LINES    = 64;
  localparam string TRACE_FILE = "sim/mem_trace.txt";

  localparam logic [15:0] CMD_END = 16'h00ff;

  logic                      clk;
  logic                      reset;
  pdp8_mem_pkg::panel_cmd_t  panel;
  pdp8_mem_pkg::word_t       switches;
  pdp8_mem_pkg::cpu_side_t   cpu;
  pdp8_mem_pkg::word_t       instruction;
  pdp8_mem_pkg::word_t       mdout;
  pdp8_mem_pkg::ext_addr_t   eaddr;
  logic                      done;

  logic [15:0] trace_mem [MAX_LINES * LINE_WORDS];
  int          num_lines;
  int          cycle_count;
  int          cycle_limit;

  memory_subsystem #(
    .NUM_FIELDS (NUM_FIELDS)
  ) memory_subsystem_i (
    .clk         (clk),
    .reset       (reset),
    .panel       (panel),
    .switches    (switches),
    .cpu         (cpu),
    .instruction (instruction),
    .mdout       (mdout),
    .eaddr       (eaddr),
    .done        (done)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Simulation stopped at %0t ns", $time);
  endtask

  task automatic check_value(input string what, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s is %o, expected %o",
                          $time, what, actual, expected));
    end
  endtask

  // Counts operations up to the end marker and rejects damaged lines
  task automatic read_trace();
    logic [15:0] cmd;
    bit          found_end;
    found_end = 1'b0;
    num_lines = 0;
    $readmemh(TRACE_FILE, trace_mem);
    for (int line = 0; line < MAX_LINES && !found_end; line++) begin
      cmd = trace_mem[line * LINE_WORDS];
      case (cmd)
        CMD_END: found_end = 1'b1;
        16'h0010, 16'h0008, 16'h0004, 16'h0002: num_lines++;
        default: abort_run($sformatf("Trace line %0d is missing or has an unknown command",
                                     line + 1));
      endcase
    end
    if (!found_end) abort_run("Trace file has no end marker");
    if (num_lines == 0) abort_run("Trace file holds no operations");
  endtask

  // One-cycle command pulse, then wait for done and compare
  task automatic apply_operation(input int line);
    int          base;
    logic [15:0] mask;
    base = line * LINE_WORDS;
    mask = trace_mem[base + 6];
    switches       = trace_mem[base + 1][11:0];
    cpu.ac         = trace_mem[base + 2][11:0];
    cpu.skip       = trace_mem[base + 3][0];
    cpu.inst_field = trace_mem[base + 4][2:0];
    cpu.data_field = trace_mem[base + 5][2:0];
    panel          = pdp8_mem_pkg::panel_cmd_t'(trace_mem[base][4:0]);
    @(posedge clk);
    #DRIVE_DELAY;
    panel = '0;
    while (!done) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    if (mask[2]) begin
      check_value($sformatf("line %0d instruction", line + 1), {4'b0, instruction},
                  trace_mem[base + 7]);
    end
    if (mask[1]) begin
      check_value($sformatf("line %0d eaddr", line + 1), {1'b0, eaddr}, trace_mem[base + 8]);
    end
    if (mask[0]) begin
      check_value($sformatf("line %0d mdout", line + 1), {4'b0, mdout}, trace_mem[base + 9]);
    end
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
        abort_run($sformatf("Timeout: done did not arrive within %0d cycles", cycle_limit));
      end
    end
  end

  initial begin
    reset       = 1'b1;
    panel       = '0;
    switches    = '0;
    cpu         = '0;
    cycle_count = 0;
    cycle_limit = 0;
    read_trace();
    cycle_limit = num_lines * LINE_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    check_value("done after reset", {15'b0, done}, 16'h0000);
    check_value("eaddr after reset", {1'b0, eaddr}, 16'o00000);
    check_value("instruction after reset", {4'b0, instruction}, 16'o7000);  // No-op
    for (int line = 0; line < num_lines; line++) begin
      apply_operation(line);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== design/memory_subsystem.sv ====
module memory_subsystem #(
  parameter int NUM_FIELDS = 2
) (
  input  logic                    clk,
  input  logic                    reset,
  input  pdp8_mem_pkg::panel_cmd_t panel,
  input  pdp8_mem_pkg::word_t     switches,
  input  pdp8_mem_pkg::cpu_side_t cpu,
  output pdp8_mem_pkg::word_t     instruction,
  output pdp8_mem_pkg::word_t     mdout,
  output pdp8_mem_pkg::ext_addr_t eaddr,
  output logic                    done
);

  pdp8_mem_pkg::major_state_e state;
  pdp8_mem_pkg::mem_req_t     mem_req;
  pdp8_mem_pkg::word_t        mdata;
  pdp8_mem_pkg::word_t        bank_rdata [NUM_FIELDS];

  major_state_seq major_state_seq_i (
    .clk         (clk),
    .reset       (reset),
    .panel       (panel),
    .instruction (instruction),
    .state       (state),
    .done        (done)
  );

  memory_address_unit #(
    .NUM_FIELDS (NUM_FIELDS)
  ) memory_address_unit_i (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .panel       (panel),
    .switches    (switches),
    .cpu         (cpu),
    .mdata       (mdata),
    .mem_req     (mem_req),
    .instruction (instruction),
    .mdout       (mdout),
    .eaddr       (eaddr)
  );

  // One bank per 4K field
  for (genvar g = 0; g < NUM_FIELDS; g++) begin : g_bank
    core_field_bank #(
      .BANK_INDEX (g),
      .NUM_FIELDS (NUM_FIELDS)
    ) core_field_bank_i (
      .clk     (clk),
      .mem_req (mem_req),
      .rdata   (bank_rdata[g])
    );
  end

  field_read_merge #(
    .NUM_FIELDS (NUM_FIELDS)
  ) field_read_merge_i (
    .clk        (clk),
    .reset      (reset),
    .req_field  (mem_req.addr[14:12]),
    .bank_rdata (bank_rdata),
    .mdata      (mdata)
  );

endmodule

// ==== design/field_read_merge.sv ====
module field_read_merge #(
  parameter int NUM_FIELDS = 2
) (
  input  logic                 clk,
  input  logic                 reset,
  input  pdp8_mem_pkg::field_t req_field,
  input  pdp8_mem_pkg::word_t  bank_rdata [NUM_FIELDS],
  output pdp8_mem_pkg::word_t  mdata
);

  pdp8_mem_pkg::field_t field_q;  // Field of the read now coming out of the banks

  always_ff @(posedge clk) begin
    if (reset) begin
      field_q <= '0;
    end else begin
      field_q <= req_field;
    end
  end

  always_comb begin
    mdata = '0;  // Field with no bank reads as zero
    for (int i = 0; i < NUM_FIELDS; i++) begin
      if (field_q == pdp8_mem_pkg::field_t'(i)) begin
        mdata = bank_rdata[i];
      end
    end
  end

endmodule

// ==== design/core_field_bank.sv ====
module core_field_bank #(
  parameter int BANK_INDEX = 0,
  parameter int NUM_FIELDS = 2
) (
  input  logic                   clk,
  input  pdp8_mem_pkg::mem_req_t mem_req,
  output pdp8_mem_pkg::word_t    rdata
);

  pdp8_mem_pkg::word_t mem [pdp8_mem_pkg::FIELD_WORDS];
  pdp8_mem_pkg::field_t req_field;
  logic [11:0]          word_addr;
  logic                 bank_write;

  if (BANK_INDEX >= NUM_FIELDS) begin : g_bad_index
    $error("core_field_bank index %0d outside %0d fields", BANK_INDEX, NUM_FIELDS);
  end

  assign req_field  = mem_req.addr[14:12];
  assign word_addr  = mem_req.addr[11:0];
  assign bank_write = mem_req.write && (req_field == pdp8_mem_pkg::field_t'(BANK_INDEX));

  // Registered read, old contents come back on a write
  always_ff @(posedge clk) begin
    if (bank_write) begin
      mem[word_addr] <= mem_req.wdata;
    end
    rdata <= mem[word_addr];
  end

endmodule

// ==== design/memory_address_unit.sv ====
module memory_address_unit #(
  parameter int NUM_FIELDS = 2
) (
  input  logic                       clk,
  input  logic                       reset,
  input  pdp8_mem_pkg::major_state_e state,
  input  pdp8_mem_pkg::panel_cmd_t   panel,
  input  pdp8_mem_pkg::word_t        switches,
  input  pdp8_mem_pkg::cpu_side_t    cpu,
  input  pdp8_mem_pkg::word_t        mdata,
  output pdp8_mem_pkg::mem_req_t     mem_req,
  output pdp8_mem_pkg::word_t        instruction,
  output pdp8_mem_pkg::word_t        mdout,
  output pdp8_mem_pkg::ext_addr_t    eaddr
);

  pdp8_mem_pkg::word_t      pc;
  pdp8_mem_pkg::word_t      next_pc;
  pdp8_mem_pkg::word_t      skip_pc;
  pdp8_mem_pkg::word_t      mdin;          // Store data for the banks
  pdp8_mem_pkg::word_t      direct_addr;
  pdp8_mem_pkg::word_t      pointer;
  pdp8_mem_pkg::panel_cmd_t panel_q;       // Command held through the panel cycle
  logic [4:0]               current_page;
  logic [2:0]               opcode;
  logic                     index_q;       // Defer went through 0010-0017

  assign opcode      = instruction[11:9];
  assign direct_addr = {(instruction[7] ? current_page : 5'b0), instruction[6:0]};  // Page bit
  assign pointer     = index_q ? mdin : mdout;

  always_comb begin
    mem_req.addr  = eaddr;
    mem_req.wdata = mdin;
    mem_req.write = 1'b0;
    case (state)
      pdp8_mem_pkg::D1: mem_req.write = index_q;  // Auto-index write back
      pdp8_mem_pkg::E1: begin
        mem_req.write = (opcode == pdp8_mem_pkg::OP_ISZ) ||
                        (opcode == pdp8_mem_pkg::OP_DCA) ||
                        (opcode == pdp8_mem_pkg::OP_JMS);
      end
      pdp8_mem_pkg::H1: mem_req.write = panel_q.deposit && !panel_q.load_addr;
      default: mem_req.write = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      eaddr       <= '0;
      instruction <= 12'o7000;  // No-op
      mdout       <= '0;
      index_q     <= 1'b0;
      panel_q     <= '0;
    end else begin
      case (state)
        pdp8_mem_pkg::IDLE: panel_q <= panel;
        pdp8_mem_pkg::F0: pc <= eaddr[11:0];
        pdp8_mem_pkg::FW: begin
          instruction <= mdata;
          mdout       <= mdata;
        end
        pdp8_mem_pkg::F1: begin
          current_page <= pc[11:7];
          next_pc      <= pc + 12'o0001;
          skip_pc      <= pc + 12'o0002;
        end
        pdp8_mem_pkg::F2: ;
        pdp8_mem_pkg::F3: begin
          if (opcode >= pdp8_mem_pkg::OP_IOT) begin
            // IOT and OPR go straight to the next fetch
            eaddr <= {cpu.inst_field, (cpu.skip ? skip_pc : next_pc)};
          end else begin
            eaddr <= {cpu.inst_field, direct_addr};
          end
        end
        pdp8_mem_pkg::D0: index_q <= (eaddr[11:3] == 9'o001);
        pdp8_mem_pkg::DW: begin
          mdout <= mdata;
          mdin  <= mdata + 12'o0001;  // Incremented pointer, stored only when indexing
        end
        pdp8_mem_pkg::D1: ;
        pdp8_mem_pkg::D2: ;
        pdp8_mem_pkg::D3: begin
          index_q <= 1'b0;
          case (opcode)
            pdp8_mem_pkg::OP_JMP, pdp8_mem_pkg::OP_JMS: eaddr <= {cpu.inst_field, pointer};
            default: eaddr <= {cpu.data_field, pointer};  // AND, TAD, ISZ, DCA
          endcase
        end
        pdp8_mem_pkg::E0: begin
          if (opcode == pdp8_mem_pkg::OP_DCA) mdin <= cpu.ac;
          else if (opcode == pdp8_mem_pkg::OP_JMS) mdin <= next_pc;  // Return address
        end
        pdp8_mem_pkg::EW: begin
          mdout <= mdata;
          if (opcode == pdp8_mem_pkg::OP_ISZ) mdin <= mdata + 12'o0001;
        end
        pdp8_mem_pkg::E1: begin
          if ((opcode == pdp8_mem_pkg::OP_ISZ) && (mdout == 12'o7777)) next_pc <= skip_pc;
        end
        pdp8_mem_pkg::E2: begin
          if (opcode == pdp8_mem_pkg::OP_JMS) next_pc <= eaddr[11:0] + 12'o0001;
        end
        pdp8_mem_pkg::E3: eaddr <= {cpu.inst_field, next_pc};
        pdp8_mem_pkg::H0: mdin <= switches;
        pdp8_mem_pkg::HW: mdout <= mdata;
        pdp8_mem_pkg::H1: begin
          if (panel_q.load_addr) begin
            eaddr <= {cpu.inst_field, (panel_q.use_max ? 12'o7777 : switches)};
          end else if (panel_q.deposit) begin
            mdout <= mdin;  // Show the deposited word
          end
        end
        pdp8_mem_pkg::H2: begin
          if (!panel_q.load_addr && (panel_q.deposit || panel_q.examine)) begin
            eaddr[11:0] <= eaddr[11:0] + 12'o0001;
          end
        end
        pdp8_mem_pkg::H3: ;
        default: ;
      endcase
    end
  end

  // Stores only follow a W phase that has settled the address
  a_write_phase: assert property (@(posedge clk) disable iff (reset)
    mem_req.write |-> (state inside {pdp8_mem_pkg::D1, pdp8_mem_pkg::E1, pdp8_mem_pkg::H1}) &&
                      ($past(state) inside {pdp8_mem_pkg::DW, pdp8_mem_pkg::EW,
                                            pdp8_mem_pkg::HW}));

  a_field_range: assert property (@(posedge clk) disable iff (reset)
    int'(eaddr[14:12]) < NUM_FIELDS);

endmodule

// ==== design/major_state_seq.sv ====
module major_state_seq (
  input  logic                       clk,
  input  logic                       reset,
  input  pdp8_mem_pkg::panel_cmd_t   panel,
  input  pdp8_mem_pkg::word_t        instruction,
  output pdp8_mem_pkg::major_state_e state,
  output logic                       done
);

  pdp8_mem_pkg::major_state_e next_state;
  pdp8_mem_pkg::major_state_e after_op;
  logic [2:0] opcode;
  logic       defer_needed;
  logic       exec_needed;
  logic       start_panel;
  logic       finish;

  assign opcode       = instruction[11:9];
  assign defer_needed = instruction[8] && (opcode < pdp8_mem_pkg::OP_IOT);  // Indirect bit
  assign exec_needed  = (opcode <= pdp8_mem_pkg::OP_JMS);
  assign start_panel  = !panel.run &&
                        (panel.load_addr || panel.deposit || panel.examine || panel.use_max);
  assign after_op     = panel.run ? pdp8_mem_pkg::F0 : pdp8_mem_pkg::IDLE;  // Keep running?

  always_comb begin
    next_state = state;
    finish     = 1'b0;
    case (state)
      pdp8_mem_pkg::IDLE: begin
        if (panel.run) next_state = pdp8_mem_pkg::F0;
        else if (start_panel) next_state = pdp8_mem_pkg::H0;
      end
      pdp8_mem_pkg::F0: next_state = pdp8_mem_pkg::FW;
      pdp8_mem_pkg::FW: next_state = pdp8_mem_pkg::F1;
      pdp8_mem_pkg::F1: next_state = pdp8_mem_pkg::F2;
      pdp8_mem_pkg::F2: next_state = pdp8_mem_pkg::F3;
      pdp8_mem_pkg::F3: begin
        if (defer_needed) begin
          next_state = pdp8_mem_pkg::D0;
        end else if (exec_needed) begin
          next_state = pdp8_mem_pkg::E0;
        end else begin
          next_state = after_op;  // JMP, IOT and OPR end here
          finish     = 1'b1;
        end
      end
      pdp8_mem_pkg::D0: next_state = pdp8_mem_pkg::DW;
      pdp8_mem_pkg::DW: next_state = pdp8_mem_pkg::D1;
      pdp8_mem_pkg::D1: next_state = pdp8_mem_pkg::D2;
      pdp8_mem_pkg::D2: next_state = pdp8_mem_pkg::D3;
      pdp8_mem_pkg::D3: begin
        if (opcode == pdp8_mem_pkg::OP_JMP) begin
          next_state = after_op;
          finish     = 1'b1;
        end else begin
          next_state = pdp8_mem_pkg::E0;
        end
      end
      pdp8_mem_pkg::E0: next_state = pdp8_mem_pkg::EW;
      pdp8_mem_pkg::EW: next_state = pdp8_mem_pkg::E1;
      pdp8_mem_pkg::E1: next_state = pdp8_mem_pkg::E2;
      pdp8_mem_pkg::E2: next_state = pdp8_mem_pkg::E3;
      pdp8_mem_pkg::E3: begin
        next_state = after_op;
        finish     = 1'b1;
      end
      pdp8_mem_pkg::H0: next_state = pdp8_mem_pkg::HW;
      pdp8_mem_pkg::HW: next_state = pdp8_mem_pkg::H1;
      pdp8_mem_pkg::H1: next_state = pdp8_mem_pkg::H2;
      pdp8_mem_pkg::H2: next_state = pdp8_mem_pkg::H3;
      pdp8_mem_pkg::H3: begin
        next_state = pdp8_mem_pkg::IDLE;  // One panel cycle per command
        finish     = 1'b1;
      end
      default: next_state = pdp8_mem_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pdp8_mem_pkg::IDLE;
      done  <= 1'b0;
    end else begin
      state <= next_state;
      done  <= finish;  // Lands in the cycle after the last phase 3
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {pdp8_mem_pkg::IDLE,
                  pdp8_mem_pkg::F0, pdp8_mem_pkg::FW, pdp8_mem_pkg::F1,
                  pdp8_mem_pkg::F2, pdp8_mem_pkg::F3,
                  pdp8_mem_pkg::D0, pdp8_mem_pkg::DW, pdp8_mem_pkg::D1,
                  pdp8_mem_pkg::D2, pdp8_mem_pkg::D3,
                  pdp8_mem_pkg::E0, pdp8_mem_pkg::EW, pdp8_mem_pkg::E1,
                  pdp8_mem_pkg::E2, pdp8_mem_pkg::E3,
                  pdp8_mem_pkg::H0, pdp8_mem_pkg::HW, pdp8_mem_pkg::H1,
                  pdp8_mem_pkg::H2, pdp8_mem_pkg::H3});

endmodule

// ==== design/pdp8_mem_pkg.sv ====
package pdp8_mem_pkg;

  // Widths with a meaning of their own
  typedef logic [11:0] word_t;      // Machine word, bit 11 is PDP-8 bit 0
  typedef logic [2:0]  field_t;     // 4K field number
  typedef logic [14:0] ext_addr_t;  // Field in [14:12], in-field address in [11:0]

  localparam int FIELD_WORDS = 4096;

  // Major states, phases 0, W, 1, 2 and 3 of each cycle group
  typedef enum logic [4:0] {
    IDLE,
    F0, FW, F1, F2, F3,  // Fetch
    D0, DW, D1, D2, D3,  // Defer
    E0, EW, E1, E2, E3,  // Execute
    H0, HW, H1, H2, H3   // Front panel
  } major_state_e;

  // Front-panel switches as seen by the machine
  typedef struct packed {
    logic load_addr;
    logic deposit;
    logic examine;
    logic run;
    logic use_max;  // Load 7777 instead of the switch register
  } panel_cmd_t;

  // Inputs from the accumulator side of the CPU
  typedef struct packed {
    word_t  ac;
    logic   skip;
    field_t inst_field;
    field_t data_field;
  } cpu_side_t;

  // One request per cycle to every field bank
  typedef struct packed {
    ext_addr_t addr;
    word_t     wdata;
    logic      write;
  } mem_req_t;

  // Memory reference opcodes, instruction bits 0 to 2
  localparam logic [2:0] OP_AND = 3'o0;
  localparam logic [2:0] OP_TAD = 3'o1;
  localparam logic [2:0] OP_ISZ = 3'o2;
  localparam logic [2:0] OP_DCA = 3'o3;
  localparam logic [2:0] OP_JMS = 3'o4;
  localparam logic [2:0] OP_JMP = 3'o5;
  localparam logic [2:0] OP_IOT = 3'o6;
  localparam logic [2:0] OP_OPR = 3'o7;

endpackage
